// ==== sdfm_defs.svh ====
// SDFM register map constants, device id, bus widths and register offsets
// include wherever widths or offsets are needed
`ifndef SDFM_DEFS_SVH
`define SDFM_DEFS_SVH

// ==================================================
// bus and channel sizes
// ==================================================
`define SDFM_DEVICE_ID 8'h07 // upper address byte of this device
`define SDFM_ADDR_W 16       // host address
`define SDFM_DATA_W 32       // register word
`define SDFM_NCH 2           // fixed by the address map

// ==================================================
// register offsets in the lower address byte
// ==================================================
// channel 1 of a pair sits 4 bytes above channel 0
`define SDFM_OFS_IFLG 8'h00    // flags, read only
`define SDFM_OFS_IFLGCLR 8'h04 // flag clear, write only
`define SDFM_OFS_CTL 8'h08     // rsten, clken, mien
`define SDFM_OFS_DFPARM 8'h0C  // data filter params
`define SDFM_OFS_CPARM 8'h14   // comparator params
`define SDFM_OFS_CMPL 8'h1C    // low thresholds
`define SDFM_OFS_CMPH 8'h24    // high thresholds
`define SDFM_OFS_FDATA 8'h34   // filter results, read only
`define SDFM_OFS_CDATA 8'h3C   // comparator results, read only

`endif

// ==== sdfm_pkg.sv ====
// shared types of the SDFM register map
// register slots double as bit indexes into the one-hot strobes
`include "sdfm_defs.svh"

package sdfm_pkg;

  // register slots, used like opcodes by decoder and consumers
  typedef enum logic [3:0] {
    REG_NONE,    // no register hit
    REG_IFLG,
    REG_IFLGCLR,
    REG_CTL,
    REG_DFPARM0,
    REG_DFPARM1,
    REG_CPARM0,
    REG_CPARM1,
    REG_CMPL0,
    REG_CMPL1,
    REG_CMPH0,
    REG_CMPH1,
    REG_FDATA0,
    REG_FDATA1,
    REG_CDATA0,
    REG_CDATA1
  } reg_id_e;

  typedef logic [2**$bits(reg_id_e)-1:0] reg_sel_t; // one-hot, indexed by reg_id_e
  typedef logic [`SDFM_DATA_W-1:0] data_word_t;     // one register word

endpackage

// ==== sdfm_bus_decode.sv ====
// host address decode of the SDFM
// turns addr, wr and rd into one-hot write and read strobes per register slot
`timescale 1ns/100ps
`include "sdfm_defs.svh"

module sdfm_bus_decode import sdfm_pkg::*;
(
  input  logic                    SYSCLK,  // system clock, for the bus checks
  input  logic                    SYSRSTn, // sync reset, active low
  input  logic [`SDFM_ADDR_W-1:0] addr,
  input  logic                    wr,
  input  logic                    rd,
  output reg_sel_t                reg_we,
  output reg_sel_t                reg_re
);

  logic     dev_hit; // upper byte is ours
  reg_id_e  reg_id;  // slot of the lower byte
  reg_sel_t slot;    // one-hot of reg_id

  assign dev_hit = (addr[`SDFM_ADDR_W-1:8] == `SDFM_DEVICE_ID);

  always_comb
  begin
    case (addr[7:0])
      `SDFM_OFS_IFLG:            reg_id = REG_IFLG;
      `SDFM_OFS_IFLGCLR:         reg_id = REG_IFLGCLR;
      `SDFM_OFS_CTL:             reg_id = REG_CTL;
      `SDFM_OFS_DFPARM:          reg_id = REG_DFPARM0;
      `SDFM_OFS_DFPARM + 8'h04:  reg_id = REG_DFPARM1;
      `SDFM_OFS_CPARM:           reg_id = REG_CPARM0;
      `SDFM_OFS_CPARM + 8'h04:   reg_id = REG_CPARM1;
      `SDFM_OFS_CMPL:            reg_id = REG_CMPL0;
      `SDFM_OFS_CMPL + 8'h04:    reg_id = REG_CMPL1;
      `SDFM_OFS_CMPH:            reg_id = REG_CMPH0;
      `SDFM_OFS_CMPH + 8'h04:    reg_id = REG_CMPH1;
      `SDFM_OFS_FDATA:           reg_id = REG_FDATA0;
      `SDFM_OFS_FDATA + 8'h04:   reg_id = REG_FDATA1;
      `SDFM_OFS_CDATA:           reg_id = REG_CDATA0;
      `SDFM_OFS_CDATA + 8'h04:   reg_id = REG_CDATA1;
      default:                   reg_id = REG_NONE; // hole in the map
    endcase
  end

  // NONE never strobes, so a miss reads zero
  always_comb
  begin
    slot = '0;
    if (dev_hit && reg_id != REG_NONE)
      slot[reg_id] = 1'b1;
  end

  assign reg_we = wr ? slot : '0;
  assign reg_re = rd ? slot : '0; // rdata follows from this

  // single master, plain strobes
  a_no_wr_rd: assert property (@(posedge SYSCLK) disable iff (!SYSRSTn) !(wr && rd))
    else $error("wr and rd high together");

endmodule

// ==== sdfm_param_regs.sv ====
// writable control registers of the SDFM, CTL, DFPARMx, CPARMx, CMPLx, CMPHx
// fields load from fixed wdata bits, channel 1 in the upper half of each output
`timescale 1ns/100ps
`include "sdfm_defs.svh"

module sdfm_param_regs import sdfm_pkg::*;
(
  input  logic        SYSCLK,
  input  logic        SYSRSTn,
  input  reg_sel_t    reg_we,
  input  data_word_t  wdata,
  output logic        reg_rsten,       // CTL
  output logic        reg_clken,
  output logic        mien,
  output logic [15:0] reg_filtdec,     // DFPARMx
  output logic [3:0]  reg_filtmode,
  output logic [7:0]  reg_filtdiv,
  output logic [1:0]  reg_filten,
  output logic [1:0]  reg_filtask,
  output logic [3:0]  reg_filtst,
  output logic [9:0]  reg_filtsh,
  output logic [15:0] reg_compdec,     // CPARMx
  output logic [3:0]  reg_compmode,
  output logic [7:0]  reg_compdiv,
  output logic [1:0]  reg_compen,
  output logic [1:0]  reg_compsen,
  output logic [3:0]  reg_compst,
  output logic [1:0]  reg_compilen,
  output logic [1:0]  reg_compihen,
  output logic [1:0]  reg_complclrflg,
  output logic [1:0]  reg_comphclrflg,
  output logic [63:0] reg_compltrd,    // CMPLx
  output logic [63:0] reg_comphtrd     // CMPHx
);

  // ==================================================
  // CTL, now on SYSCLK
  // ==================================================
  always_ff @(posedge SYSCLK)
  begin
    if (!SYSRSTn)
    begin
      reg_rsten <= 1'b0;
      reg_clken <= 1'b0;
      mien      <= 1'b0;
    end
    else if (reg_we[REG_CTL])
    begin
      reg_rsten <= wdata[0];
      reg_clken <= wdata[1];
      mien      <= wdata[4]; // master irq enable
    end
  end

  // data filter params
  always_ff @(posedge SYSCLK)
  begin
    if (!SYSRSTn)
    begin
      reg_filtdec  <= '0;
      reg_filtmode <= '0;
      reg_filtdiv  <= '0;
      reg_filten   <= '0;
      reg_filtask  <= '0;
      reg_filtst   <= '0;
      reg_filtsh   <= '0;
    end
    else
    begin
      for (int i = 0; i < `SDFM_NCH; i++)
      begin
        if (reg_we[int'(REG_DFPARM0) + i])
        begin
          reg_filtdec[i*8 +: 8]  <= wdata[7:0];   // DOSR
          reg_filtmode[i*2 +: 2] <= wdata[9:8];
          reg_filtdiv[i*4 +: 4]  <= wdata[15:12];
          reg_filten[i]          <= wdata[16];
          reg_filtask[i]         <= wdata[17];    // AEN
          reg_filtst[i*2 +: 2]   <= wdata[21:20];
          reg_filtsh[i*5 +: 5]   <= wdata[28:24]; // output shift
        end
      end
    end
  end

  // comparator params
  always_ff @(posedge SYSCLK)
  begin
    if (!SYSRSTn)
    begin
      reg_compdec     <= '0;
      reg_compmode    <= '0;
      reg_compdiv     <= '0;
      reg_compen      <= '0;
      reg_compsen     <= '0;
      reg_compst      <= '0;
      reg_compilen    <= '0;
      reg_compihen    <= '0;
      reg_complclrflg <= '0;
      reg_comphclrflg <= '0;
    end
    else
    begin
      for (int i = 0; i < `SDFM_NCH; i++)
      begin
        if (reg_we[int'(REG_CPARM0) + i])
        begin
          reg_compdec[i*8 +: 8]  <= wdata[7:0];
          reg_compmode[i*2 +: 2] <= wdata[9:8];
          reg_compdiv[i*4 +: 4]  <= wdata[15:12];
          reg_compen[i]          <= wdata[16];
          reg_compsen[i]         <= wdata[17]; // signed compare
          reg_compst[i*2 +: 2]   <= wdata[21:20];
          reg_compilen[i]        <= wdata[24];
          reg_compihen[i]        <= wdata[25];
          reg_complclrflg[i]     <= wdata[28]; // hw clear of LF
          reg_comphclrflg[i]     <= wdata[29]; // hw clear of HF
        end
      end
    end
  end

  // ==================================================
  // thresholds, whole word
  // ==================================================
  always_ff @(posedge SYSCLK)
  begin
    if (!SYSRSTn)
    begin
      reg_compltrd <= '0;
      reg_comphtrd <= '0;
    end
    else
    begin
      for (int i = 0; i < `SDFM_NCH; i++)
      begin
        if (reg_we[int'(REG_CMPL0) + i])
          reg_compltrd[i*32 +: 32] <= wdata;
        if (reg_we[int'(REG_CMPH0) + i])
          reg_comphtrd[i*32 +: 32] <= wdata;
      end
    end
  end

endmodule

// ==== sdfm_data_capture.sv ====
// FDATAx and CDATAx result registers
// each channel loads on its own update pulse and holds otherwise
`timescale 1ns/100ps
`include "sdfm_defs.svh"

module sdfm_data_capture
(
  input  logic                                SYSCLK,
  input  logic                                SYSRSTn,
  input  logic [`SDFM_NCH*`SDFM_DATA_W-1:0]  filt_data_out,
  input  logic [`SDFM_NCH-1:0]               filt_data_update, // one pulse per result
  input  logic [`SDFM_NCH*`SDFM_DATA_W-1:0]  comp_data_out,
  input  logic [`SDFM_NCH-1:0]               comp_data_update,
  output logic [`SDFM_NCH*`SDFM_DATA_W-1:0]  fdata,
  output logic [`SDFM_NCH*`SDFM_DATA_W-1:0]  cdata
);

  always_ff @(posedge SYSCLK)
  begin
    if (!SYSRSTn)
    begin
      fdata <= '0;
      cdata <= '0;
    end
    else
    begin
      for (int i = 0; i < `SDFM_NCH; i++)
      begin
        // own channel's bit only, the other channel keeps its value
        if (filt_data_update[i])
          fdata[i*`SDFM_DATA_W +: `SDFM_DATA_W] <= filt_data_out[i*`SDFM_DATA_W +: `SDFM_DATA_W];
        if (comp_data_update[i])
          cdata[i*`SDFM_DATA_W +: `SDFM_DATA_W] <= comp_data_out[i*`SDFM_DATA_W +: `SDFM_DATA_W];
      end
    end
  end

endmodule

// ==== sdfm_irq_flags.sv ====
// comparator LF/HF flags and the IRQF interrupt flag
// flags follow compare updates, clear by IFLGCLR or in hardware-clear mode
`timescale 1ns/100ps
`include "sdfm_defs.svh"

module sdfm_irq_flags import sdfm_pkg::*;
(
  input  logic                 SYSCLK,
  input  logic                 SYSRSTn,
  input  reg_sel_t             reg_we,
  input  data_word_t           wdata,
  input  logic [`SDFM_NCH-1:0] comp_data_update,
  input  logic [`SDFM_NCH-1:0] comp_data_low,   // below low threshold
  input  logic [`SDFM_NCH-1:0] comp_data_high,  // at or above high threshold
  input  logic                 mien,
  input  logic [`SDFM_NCH-1:0] compilen,
  input  logic [`SDFM_NCH-1:0] compihen,
  input  logic [`SDFM_NCH-1:0] complclrflg,
  input  logic [`SDFM_NCH-1:0] comphclrflg,
  output logic [`SDFM_NCH-1:0] flg_lf,
  output logic [`SDFM_NCH-1:0] flg_hf,
  output logic                 irq              // IRQF itself
);

  logic clr_wr;   // IFLGCLR write this cycle
  logic irq_src;  // some enabled flag is up

  assign clr_wr  = reg_we[REG_IFLGCLR];
  assign irq_src = |((compilen & flg_lf) | (compihen & flg_hf));

  // ==================================================
  // LF / HF per channel
  // ==================================================
  always_ff @(posedge SYSCLK)
  begin
    if (!SYSRSTn)
    begin
      flg_lf <= '0;
      flg_hf <= '0;
    end
    else
    begin
      for (int i = 0; i < `SDFM_NCH; i++)
      begin
        if (comp_data_update[i] && complclrflg[i])
          flg_lf[i] <= comp_data_low[i];  // hw clear, copy compare
        else if (comp_data_update[i] && comp_data_low[i])
          flg_lf[i] <= 1'b1;              // set and hold
        else if (clr_wr && wdata[8 + i])
          flg_lf[i] <= 1'b0;
        if (comp_data_update[i] && comphclrflg[i])
          flg_hf[i] <= comp_data_high[i];
        else if (comp_data_update[i] && comp_data_high[i])
          flg_hf[i] <= 1'b1;
        else if (clr_wr && wdata[12 + i])
          flg_hf[i] <= 1'b0;
      end
    end
  end

  // IRQF, set wins over bit 31 clear
  always_ff @(posedge SYSCLK)
  begin
    if (!SYSRSTn)
      irq <= 1'b0;
    else if (mien && irq_src)
      irq <= 1'b1;
    else if (clr_wr && wdata[31])
      irq <= 1'b0;
  end

endmodule

// ==== sdfm_read_mux.sv ====
// read side of the SDFM register map
// packs the selected register into rdata, reserved bits and misses read zero
`timescale 1ns/100ps
`include "sdfm_defs.svh"

module sdfm_read_mux import sdfm_pkg::*;
(
  input  reg_sel_t    reg_re,
  input  logic [1:0]  flg_lf,
  input  logic [1:0]  flg_hf,
  input  logic        irq,
  input  logic        reg_rsten,
  input  logic        reg_clken,
  input  logic        mien,
  input  logic [15:0] reg_filtdec,
  input  logic [3:0]  reg_filtmode,
  input  logic [7:0]  reg_filtdiv,
  input  logic [1:0]  reg_filten,
  input  logic [1:0]  reg_filtask,
  input  logic [3:0]  reg_filtst,
  input  logic [9:0]  reg_filtsh,
  input  logic [15:0] reg_compdec,
  input  logic [3:0]  reg_compmode,
  input  logic [7:0]  reg_compdiv,
  input  logic [1:0]  reg_compen,
  input  logic [1:0]  reg_compsen,
  input  logic [3:0]  reg_compst,
  input  logic [1:0]  reg_compilen,
  input  logic [1:0]  reg_compihen,
  input  logic [1:0]  reg_complclrflg,
  input  logic [1:0]  reg_comphclrflg,
  input  logic [63:0] reg_compltrd,
  input  logic [63:0] reg_comphtrd,
  input  logic [63:0] fdata,
  input  logic [63:0] cdata,
  output data_word_t  rdata
);

  // reg_re is one-hot or zero, so OR-ing the hits is enough
  always_comb
  begin
    rdata = '0;
    if (reg_re[REG_IFLG])
      rdata |= {irq, 17'b0, flg_hf, 2'b0, flg_lf, 8'b0}; // AF bits read zero
    if (reg_re[REG_CTL])
      rdata |= {27'b0, mien, 2'b0, reg_clken, reg_rsten};
    for (int i = 0; i < `SDFM_NCH; i++)
    begin
      if (reg_re[int'(REG_DFPARM0) + i])
        rdata |= {3'b0, reg_filtsh[i*5 +: 5], 2'b0, reg_filtst[i*2 +: 2],
                  2'b0, reg_filtask[i], reg_filten[i], reg_filtdiv[i*4 +: 4],
                  2'b0, reg_filtmode[i*2 +: 2], reg_filtdec[i*8 +: 8]};
      if (reg_re[int'(REG_CPARM0) + i])
        rdata |= {2'b0, reg_comphclrflg[i], reg_complclrflg[i], 2'b0,
                  reg_compihen[i], reg_compilen[i], 2'b0, reg_compst[i*2 +: 2],
                  2'b0, reg_compsen[i], reg_compen[i], reg_compdiv[i*4 +: 4],
                  2'b0, reg_compmode[i*2 +: 2], reg_compdec[i*8 +: 8]};
      if (reg_re[int'(REG_CMPL0) + i])
        rdata |= reg_compltrd[i*32 +: 32];
      if (reg_re[int'(REG_CMPH0) + i])
        rdata |= reg_comphtrd[i*32 +: 32];
      if (reg_re[int'(REG_FDATA0) + i])
        rdata |= fdata[i*32 +: 32];
      if (reg_re[int'(REG_CDATA0) + i])
        rdata |= cdata[i*32 +: 32];
    end
  end

endmodule

// ==== sdfm_regmap.sv ====
// SDFM register map top, host bus in, field outputs and irq out
// decoder, register blocks and read mux share the bus, no arbiter
`timescale 1ns/100ps
`include "sdfm_defs.svh"

module sdfm_regmap import sdfm_pkg::*;
(
  input  logic                    SYSCLK,
  input  logic                    SYSRSTn,
  input  logic [`SDFM_ADDR_W-1:0] addr,
  input  logic                    wr,
  input  logic                    rd,
  input  data_word_t              wdata,
  output data_word_t              rdata,   // zero when nothing is read
  input  logic [63:0]             filt_data_out,
  input  logic [1:0]              filt_data_update,
  input  logic [63:0]             comp_data_out,
  input  logic [1:0]              comp_data_update,
  input  logic [1:0]              comp_data_low,
  input  logic [1:0]              comp_data_high,
  output logic                    reg_rsten,
  output logic                    reg_clken,
  output logic [15:0]             reg_filtdec,
  output logic [3:0]              reg_filtmode,
  output logic [7:0]              reg_filtdiv,
  output logic [1:0]              reg_filten,
  output logic [1:0]              reg_filtask,
  output logic [3:0]              reg_filtst,
  output logic [9:0]              reg_filtsh,
  output logic [15:0]             reg_compdec,
  output logic [3:0]              reg_compmode,
  output logic [7:0]              reg_compdiv,
  output logic [1:0]              reg_compen,
  output logic [1:0]              reg_compsen,
  output logic [3:0]              reg_compst,
  output logic [1:0]              reg_compilen,
  output logic [1:0]              reg_compihen,
  output logic [1:0]              reg_complclrflg,
  output logic [1:0]              reg_comphclrflg,
  output logic [63:0]             reg_compltrd,
  output logic [63:0]             reg_comphtrd,
  output logic                    irq
);

  reg_sel_t    reg_we;  // one-hot write strobes
  reg_sel_t    reg_re;  // one-hot read strobes
  logic        mien;
  logic [1:0]  flg_lf;
  logic [1:0]  flg_hf;
  logic [63:0] fdata;
  logic [63:0] cdata;

  sdfm_bus_decode sdfm_bus_decode_i (.*);

  sdfm_param_regs sdfm_param_regs_i (.*);

  sdfm_data_capture sdfm_data_capture_i (.*);

  sdfm_irq_flags sdfm_irq_flags_i (
    .SYSCLK, .SYSRSTn, .reg_we, .wdata,
    .comp_data_update, .comp_data_low, .comp_data_high, .mien,
    .compilen    (reg_compilen),
    .compihen    (reg_compihen),
    .complclrflg (reg_complclrflg),
    .comphclrflg (reg_comphclrflg),
    .flg_lf, .flg_hf, .irq
  );

  sdfm_read_mux sdfm_read_mux_i (.*);

endmodule

// ==== tb_sdfm_regmap.sv ====
// testbench of the SDFM register map, drives the host bus and the datapath pulses
// concurrent assertions compare rdata, field outputs and irq with models kept here
`timescale 1ns/100ps
`include "sdfm_defs.svh"

module tb_sdfm_regmap import sdfm_pkg::*;
();

  localparam int CLK_NS       = 100;
  localparam int N_TESTS      = 6;
  localparam int MAX_ACCESSES = 200; // all tests together, 2 cycles each
  localparam int WATCHDOG_CYC = 5 + 2*MAX_ACCESSES + N_TESTS + 100;
  localparam data_word_t CTL_MASK = 32'h0000_0013; // rsten, clken, mien
  localparam data_word_t DFP_MASK = 32'h1F33_F3FF;
  localparam data_word_t CP_MASK  = 32'h3333_F3FF;

  logic                    SYSCLK, SYSRSTn, wr, rd;
  logic [`SDFM_ADDR_W-1:0] addr;
  data_word_t              wdata, rdata;
  logic [63:0]             filt_data_out, comp_data_out;
  logic [1:0]              filt_data_update, comp_data_update, comp_data_low, comp_data_high;
  logic                    reg_rsten, reg_clken, irq;
  logic [15:0]             reg_filtdec, reg_compdec;
  logic [3:0]              reg_filtmode, reg_filtst, reg_compmode, reg_compst;
  logic [7:0]              reg_filtdiv, reg_compdiv;
  logic [1:0]              reg_filten, reg_filtask, reg_compen, reg_compsen;
  logic [1:0]              reg_compilen, reg_compihen, reg_complclrflg, reg_comphclrflg;
  logic [9:0]              reg_filtsh;
  logic [63:0]             reg_compltrd, reg_comphtrd;
  logic [219:0]            fields_act; // every field output, fixed order

  // ==================================================
  // models and check controls
  // ==================================================
  data_word_t  ctl_m = '0;
  data_word_t  dfp_m[2] = '{default: '0};
  data_word_t  cp_m[2] = '{default: '0};
  data_word_t  cmpl_m[2] = '{default: '0};
  data_word_t  cmph_m[2] = '{default: '0};
  data_word_t  fdata_m[2] = '{default: '0};
  data_word_t  cdata_m[2] = '{default: '0};
  logic [1:0]  lf_m = '0, hf_m = '0;
  logic        irq_m = 1'b0;
  logic        rd_chk = 1'b0, fld_chk = 1'b0, irq_off = 1'b0, irq_trig = 1'b0;
  data_word_t  rd_exp = '0;
  logic [219:0] fld_exp = '0;
  logic [31:0] lfsr = 32'hf32805c6;
  string       test_name = "reset";
  int          errors = 0, err_base = 0, n_tests = 0, n_failed = 0;

  sdfm_regmap sdfm_regmap_i (.*);

  assign fields_act = {reg_rsten, reg_clken, reg_filtdec, reg_filtmode, reg_filtdiv,
                       reg_filten, reg_filtask, reg_filtst, reg_filtsh, reg_compdec,
                       reg_compmode, reg_compdiv, reg_compen, reg_compsen, reg_compst,
                       reg_compilen, reg_compihen, reg_complclrflg, reg_comphclrflg,
                       reg_compltrd, reg_comphtrd};

  initial
  begin
    SYSCLK = 1'b0;
    forever #(CLK_NS/2) SYSCLK = ~SYSCLK;
  end

  // galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [15:0] reg_addr(logic [7:0] ofs, int ch);
    return {`SDFM_DEVICE_ID, ofs + 8'(4*ch)}; // channel 1 sits 4 above
  endfunction

  // field outputs as the bit table places them, channel 1 upper
  function automatic logic [219:0] fields_model();
    return {ctl_m[0], ctl_m[1],
            dfp_m[1][7:0], dfp_m[0][7:0], dfp_m[1][9:8], dfp_m[0][9:8],
            dfp_m[1][15:12], dfp_m[0][15:12], dfp_m[1][16], dfp_m[0][16],
            dfp_m[1][17], dfp_m[0][17], dfp_m[1][21:20], dfp_m[0][21:20],
            dfp_m[1][28:24], dfp_m[0][28:24],
            cp_m[1][7:0], cp_m[0][7:0], cp_m[1][9:8], cp_m[0][9:8],
            cp_m[1][15:12], cp_m[0][15:12], cp_m[1][16], cp_m[0][16],
            cp_m[1][17], cp_m[0][17], cp_m[1][21:20], cp_m[0][21:20],
            cp_m[1][24], cp_m[0][24], cp_m[1][25], cp_m[0][25],
            cp_m[1][28], cp_m[0][28], cp_m[1][29], cp_m[0][29],
            cmpl_m[1], cmpl_m[0], cmph_m[1], cmph_m[0]};
  endfunction

  function automatic data_word_t iflg_model();
    return {irq_m, 17'b0, hf_m, 2'b0, lf_m, 8'b0}; // AF bits stay zero
  endfunction

  // ==================================================
  // checks
  // ==================================================
  a_rdata: assert property (@(posedge SYSCLK) disable iff (!SYSRSTn) rd_chk |-> rdata == rd_exp)
    else
    begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", test_name, $sampled(rd_exp), $sampled(rdata));
    end
  a_rd_idle: assert property (@(posedge SYSCLK) disable iff (!SYSRSTn) !rd |-> rdata == '0)
    else
    begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", test_name, 32'h0, $sampled(rdata));
    end
  a_fields: assert property (@(posedge SYSCLK) disable iff (!SYSRSTn)
    fld_chk |-> fields_act == fld_exp)
    else
    begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", test_name, $sampled(fld_exp),
               $sampled(fields_act));
    end
  a_irq_masked: assert property (@(posedge SYSCLK) disable iff (!SYSRSTn) irq_off |-> !irq)
    else
    begin
      errors++;
      $display("ERROR %s: expected %b, actual %b", test_name, 1'b0, $sampled(irq));
    end
  // irq comes up exactly two cycles after the setting update
  a_irq_rise: assert property (@(posedge SYSCLK) disable iff (!SYSRSTn)
    $past(irq_trig, 2) |-> $rose(irq))
    else
    begin
      errors++;
      $display("%s: irq did not rise two cycles after the update", test_name);
    end

  // ==================================================
  // bus and datapath tasks
  // ==================================================
  task automatic bus_write(logic [15:0] a, data_word_t d);
    @(posedge SYSCLK);
    addr  <= a;
    wdata <= d;
    wr    <= 1'b1;
    @(posedge SYSCLK);
    wr    <= 1'b0;
  endtask

  task automatic bus_read(logic [15:0] a, data_word_t exp);
    @(posedge SYSCLK);
    addr   <= a;
    rd     <= 1'b1;
    rd_chk <= 1'b1;
    rd_exp <= exp;
    @(posedge SYSCLK); // checked on this edge
    rd     <= 1'b0;
    rd_chk <= 1'b0;
  endtask

  task automatic check_fields();
    @(posedge SYSCLK);
    fld_chk <= 1'b1;
    fld_exp <= fields_model();
    @(posedge SYSCLK);
    fld_chk <= 1'b0;
  endtask

  // one-cycle update, random data on both channels
  task automatic update_pulse(logic filt, logic [1:0] upd, logic [1:0] lo, logic [1:0] hi,
                              logic trig);
    data_word_t d[2];
    d[0] = rand_bits(32);
    d[1] = rand_bits(32);
    @(posedge SYSCLK);
    if (filt)
    begin
      filt_data_out    <= {d[1], d[0]};
      filt_data_update <= upd;
    end
    else
    begin
      comp_data_out    <= {d[1], d[0]};
      comp_data_update <= upd;
      comp_data_low    <= lo;
      comp_data_high   <= hi;
      irq_trig         <= trig;
    end
    for (int i = 0; i < 2; i++)
    begin
      if (upd[i] && filt)
        fdata_m[i] = d[i];
      if (upd[i] && !filt)
        cdata_m[i] = d[i];
    end
    @(posedge SYSCLK);
    filt_data_update <= 2'b0;
    comp_data_update <= 2'b0;
    irq_trig         <= 1'b0;
  endtask

  task automatic start_test(string name);
    test_name = name;
    err_base  = errors;
  endtask

  task automatic end_test();
    @(posedge SYSCLK); // last check reports first
    n_tests++;
    if (errors != err_base)
      n_failed++;
    $display("%s: %0d errors", test_name, errors - err_base);
  endtask

  // ==================================================
  // tests
  // ==================================================
  task automatic test_readback();
    data_word_t w;
    start_test("readback");
    w = rand_bits(32);
    ctl_m = w & CTL_MASK;
    bus_write(reg_addr(`SDFM_OFS_CTL, 0), w);
    for (int i = 0; i < 2; i++)
    begin
      w = rand_bits(32);
      dfp_m[i] = w & DFP_MASK;
      bus_write(reg_addr(`SDFM_OFS_DFPARM, i), w);
      w = rand_bits(32);
      cp_m[i] = w & CP_MASK;
      bus_write(reg_addr(`SDFM_OFS_CPARM, i), w);
      cmpl_m[i] = rand_bits(32);
      bus_write(reg_addr(`SDFM_OFS_CMPL, i), cmpl_m[i]);
      cmph_m[i] = rand_bits(32);
      bus_write(reg_addr(`SDFM_OFS_CMPH, i), cmph_m[i]);
    end
    check_fields();
    bus_read(reg_addr(`SDFM_OFS_CTL, 0), ctl_m);
    for (int i = 0; i < 2; i++)
    begin
      bus_read(reg_addr(`SDFM_OFS_DFPARM, i), dfp_m[i]);
      bus_read(reg_addr(`SDFM_OFS_CPARM, i), cp_m[i]);
      bus_read(reg_addr(`SDFM_OFS_CMPL, i), cmpl_m[i]);
      bus_read(reg_addr(`SDFM_OFS_CMPH, i), cmph_m[i]);
    end
    end_test();
  endtask

  task automatic test_decode();
    logic [15:0] bad[4];
    bad[0] = {8'h17, `SDFM_OFS_CTL};  // foreign device
    bad[1] = {8'h06, `SDFM_OFS_CMPL};
    bad[2] = reg_addr(8'h2C, 0);      // holes in the map
    bad[3] = reg_addr(8'h30, 0);
    start_test("decode");
    for (int k = 0; k < 4; k++)
      bus_write(bad[k], rand_bits(32));
    check_fields();
    for (int k = 0; k < 4; k++)
      bus_read(bad[k], '0);
    bus_read(reg_addr(`SDFM_OFS_CTL, 0), ctl_m);
    end_test();
  endtask

  task automatic test_capture();
    start_test("capture");
    for (int f = 1; f >= 0; f--)
    begin
      for (int i = 0; i < 2; i++)
      begin
        update_pulse(1'(f), 2'(1 << i), 2'b0, 2'b0, 1'b0); // compare results low
        for (int j = 0; j < 2; j++)
        begin
          bus_read(reg_addr(`SDFM_OFS_FDATA, j), fdata_m[j]);
          bus_read(reg_addr(`SDFM_OFS_CDATA, j), cdata_m[j]);
        end
      end
    end
    end_test();
  endtask

  // set-and-hold or hardware-clear, interrupts off
  task automatic test_flags(string name, logic hw);
    logic [1:0] upd, lo, hi;
    data_word_t clr;
    start_test(name);
    for (int i = 0; i < 2; i++)
    begin
      cp_m[i] = hw ? 32'h3000_0000 : '0; // LCLRFLG, HCLRFLG
      bus_write(reg_addr(`SDFM_OFS_CPARM, i), cp_m[i]);
    end
    for (int k = 0; k < 10; k++)
    begin
      upd = 2'(rand_bits(2));
      lo  = 2'(rand_bits(2));
      hi  = 2'(rand_bits(2));
      update_pulse(1'b0, upd, lo, hi, 1'b0);
      lf_m = hw ? ((lf_m & ~upd) | (lo & upd)) : (lf_m | (lo & upd));
      hf_m = hw ? ((hf_m & ~upd) | (hi & upd)) : (hf_m | (hi & upd));
      bus_read(reg_addr(`SDFM_OFS_IFLG, 0), iflg_model());
      if (k % 3 == 2)
      begin
        clr = rand_bits(32) & 32'h8000_3300;
        lf_m &= ~clr[9:8];
        hf_m &= ~clr[13:12];
        bus_write(reg_addr(`SDFM_OFS_IFLGCLR, 0), clr);
        bus_read(reg_addr(`SDFM_OFS_IFLG, 0), iflg_model());
      end
    end
    lf_m = '0;
    hf_m = '0;
    bus_write(reg_addr(`SDFM_OFS_IFLGCLR, 0), 32'h0000_3300);
    bus_read(reg_addr(`SDFM_OFS_IFLG, 0), iflg_model());
    end_test();
  endtask

  task automatic test_irq();
    logic [1:0] lo, hi;
    start_test("irq");
    ctl_m = '0;
    bus_write(reg_addr(`SDFM_OFS_CTL, 0), ctl_m);
    for (int i = 0; i < 2; i++)
    begin
      cp_m[i] = 32'h0300_0000; // ILEN, IHEN
      bus_write(reg_addr(`SDFM_OFS_CPARM, i), cp_m[i]);
    end
    @(posedge SYSCLK);
    irq_off <= 1'b1; // MIEN off, irq must stay low
    update_pulse(1'b0, 2'b01, 2'b01, 2'b00, 1'b0);
    lf_m = 2'b01;
    bus_read(reg_addr(`SDFM_OFS_IFLG, 0), iflg_model());
    lf_m = '0;
    bus_write(reg_addr(`SDFM_OFS_IFLGCLR, 0), 32'h0000_3300);
    irq_off <= 1'b0;
    ctl_m = 32'h0000_0010;
    bus_write(reg_addr(`SDFM_OFS_CTL, 0), ctl_m);
    for (int ch = 0; ch < 2; ch++)
    begin
      lo = (rand_bits(1) == 32'd1) ? 2'(1 << ch) : 2'b00;
      hi = (lo == 2'b00) ? 2'(1 << ch) : 2'b00;
      update_pulse(1'b0, 2'(1 << ch), lo, hi, 1'b1);
      lf_m  = lo;
      hf_m  = hi;
      irq_m = 1'b1;
      bus_read(reg_addr(`SDFM_OFS_IFLG, 0), iflg_model());
      bus_write(reg_addr(`SDFM_OFS_IFLGCLR, 0), 32'h8000_0000); // flag still up, set wins
      bus_read(reg_addr(`SDFM_OFS_IFLG, 0), iflg_model());
      lf_m = '0;
      hf_m = '0;
      bus_write(reg_addr(`SDFM_OFS_IFLGCLR, 0), 32'h0000_3300);
      bus_read(reg_addr(`SDFM_OFS_IFLG, 0), iflg_model());
      irq_m = 1'b0;
      bus_write(reg_addr(`SDFM_OFS_IFLGCLR, 0), 32'h8000_0000);
      bus_read(reg_addr(`SDFM_OFS_IFLG, 0), iflg_model());
    end
    end_test();
  endtask

  initial
  begin
    SYSRSTn          = 1'b0;
    addr             = '0;
    wr               = 1'b0;
    rd               = 1'b0;
    wdata            = '0;
    filt_data_out    = '0;
    comp_data_out    = '0;
    filt_data_update = '0;
    comp_data_update = '0;
    comp_data_low    = '0;
    comp_data_high   = '0;
    repeat (5) @(posedge SYSCLK);
    SYSRSTn <= 1'b1;
    test_readback();
    test_decode();
    test_capture();
    test_flags("set_hold", 1'b0);
    test_flags("hw_clear", 1'b1);
    test_irq();
    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // hang guard
  initial
  begin
    #(WATCHDOG_CYC * CLK_NS);
    $display("watchdog expired, tests did not finish in %0d cycles", WATCHDOG_CYC);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
sdfm_pkg.sv
sdfm_bus_decode.sv
sdfm_param_regs.sv
sdfm_data_capture.sv
sdfm_irq_flags.sv
sdfm_read_mux.sv
sdfm_regmap.sv
tb_sdfm_regmap.sv

// ==== run.sh ====
#!/bin/sh
# build and run the SDFM register map testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_sdfm_regmap
out=$(./obj_dir/Vtb_sdfm_regmap)
echo "$out"
echo "$out" | grep -qx "TEST OK"
